/* Makefile */
VERILATOR  ?= verilator
FLAGS      ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing -Wall
TOP        ?= exu_tb
FILELIST   ?= list.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
PASS_MSG   := Test completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module exu_top

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* list.f */
+incdir+verilog
verilog/exu_pkg.sv
verilog/alu.sv
verilog/lsu.sv
verilog/csr_file.sv
verilog/exu.sv
verilog/data_sram.sv
verilog/exu_top.sv
verification/exu_tb.sv

/* verification/exu_tb.sv */
`timescale 1ns/1ps
`include "exu_consts.svh"

module exu_tb;

	typedef struct {
		string name;
		logic [31:0] pc, src1, src2, store_data, branch_target;
		logic [4:0] rd;
		logic rd_wen;
		exu_pkg::alu_op_e alu_op;
		exu_pkg::mem_op_e mem_op;
		exu_pkg::jump_e jump;
		exu_pkg::csr_op_e csr_op;
		logic [11:0] csr_idx;
		logic exp_wen, exp_redir;
		logic [31:0] exp_data, exp_rpc;
		int n_csr;
		logic [11:0] csr_a [2];
		logic [31:0] csr_e [2];
	} row_t;

	logic clk, rst, in_valid, rd_wen, allowin, done_valid, redirect_valid, rf_wen;
	logic [31:0] pc, src1, src2, store_data, branch_target, redirect_pc, rf_wdata, csr_rdata;
	logic [4:0] rd, rf_waddr;
	logic [11:0] csr_idx, csr_raddr;
	exu_pkg::alu_op_e alu_op;
	exu_pkg::mem_op_e mem_op;
	exu_pkg::jump_e jump;
	exu_pkg::csr_op_e csr_op;

	row_t rows[$];
	logic [7:0] bmem [1024];
	logic [31:0] csr_model [4];
	logic [11:0] rd_q_addr[$];
	logic [31:0] rd_q_exp[$];
	integer seed = 32'h26ad;
	int checked = 0, passed = 0, errors = 0;
	bit armed = 0, stall_seen = 0, timed_out = 0;

	exu_top i_exu_top (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// reference rv32i integer semantics
	function automatic logic [31:0] alu_model(exu_pkg::alu_op_e op, logic [31:0] a,
		logic [31:0] b);
		case (op)
			exu_pkg::ALU_ADD: return a + b;
			exu_pkg::ALU_SUB: return a - b;
			exu_pkg::ALU_SLL: return a << b[4:0];
			exu_pkg::ALU_SRL: return a >> b[4:0];
			exu_pkg::ALU_SRA: return $unsigned($signed(a) >>> b[4:0]);
			exu_pkg::ALU_XOR: return a ^ b;
			exu_pkg::ALU_OR: return a | b;
			exu_pkg::ALU_AND: return a & b;
			exu_pkg::ALU_SLT, exu_pkg::ALU_LT: return {31'd0, $signed(a) < $signed(b)};
			exu_pkg::ALU_SLTU, exu_pkg::ALU_LTU: return {31'd0, a < b};
			exu_pkg::ALU_EQ: return {31'd0, a == b};
			exu_pkg::ALU_NE: return {31'd0, a != b};
			exu_pkg::ALU_GE: return {31'd0, $signed(a) >= $signed(b)};
			exu_pkg::ALU_GEU: return {31'd0, a >= b};
			default: return b;
		endcase
	endfunction

	function automatic int csr_slot(logic [11:0] idx);
		case (idx)
			`CSR_MSTATUS: return 0;
			`CSR_MTVEC: return 1;
			`CSR_MEPC: return 2;
			default: return 3;
		endcase
	endfunction

	function automatic row_t blank_row(string name);
		row_t r;
		r.name = name;
		r.pc = 32'h0;
		r.src1 = 32'h0;
		r.src2 = 32'h0;
		r.store_data = 32'h0;
		r.branch_target = 32'h0;
		r.rd = 5'd0;
		r.rd_wen = 1'b0;
		r.alu_op = exu_pkg::ALU_ADD;
		r.mem_op = exu_pkg::MEM_NONE;
		r.jump = exu_pkg::JUMP_NONE;
		r.csr_op = exu_pkg::CSR_OP_NONE;
		r.csr_idx = 12'h0;
		r.exp_wen = 1'b0;
		r.exp_redir = 1'b0;
		r.exp_data = 32'h0;
		r.exp_rpc = 32'h0;
		r.n_csr = 0;
		return r;
	endfunction

	task automatic add_alu(exu_pkg::alu_op_e op, logic [31:0] a, logic [31:0] b,
		logic [4:0] rdi, logic wen);
		row_t r;
		r = blank_row(op.name());
		r.alu_op = op;
		r.src1 = a;
		r.src2 = b;
		r.rd = rdi;
		r.rd_wen = wen;
		r.exp_wen = wen;
		r.exp_data = alu_model(op, a, b);
		rows.push_back(r);
	endtask

	task automatic add_jump(exu_pkg::jump_e kind, exu_pkg::alu_op_e op, logic [31:0] pci,
		logic [31:0] a, logic [31:0] b, logic [31:0] target);
		row_t r;
		logic [31:0] res;
		r = blank_row(kind.name());
		res = alu_model(op, a, b);
		r.jump = kind;
		r.alu_op = op;
		r.pc = pci;
		r.src1 = a;
		r.src2 = b;
		r.branch_target = target;
		if (kind == exu_pkg::JUMP_BRANCH) begin
			r.exp_redir = res[0];
			r.exp_rpc = target;
		end else begin
			r.rd = 5'd1;
			r.rd_wen = 1'b1;
			r.exp_wen = 1'b1;
			r.exp_data = pci + 32'd4;
			r.exp_redir = 1'b1;
			r.exp_rpc = (kind == exu_pkg::JUMP_JALR) ? (res & ~32'd1) : res;
		end
		rows.push_back(r);
	endtask

	task automatic add_mem(exu_pkg::mem_op_e op, logic [31:0] base, logic [31:0] off,
		logic [31:0] data, logic [4:0] rdi);
		row_t r;
		logic [9:0] a;
		r = blank_row(op.name());
		a = 10'(base + off);
		r.mem_op = op;
		r.src1 = base;
		r.src2 = off;
		r.store_data = data;
		case (op)
			exu_pkg::MEM_SB: bmem[a] = data[7:0];
			exu_pkg::MEM_SH: {bmem[a+1], bmem[a]} = data[15:0];
			exu_pkg::MEM_SW: {bmem[a+3], bmem[a+2], bmem[a+1], bmem[a]} = data;
			default: begin
				r.rd = rdi;
				r.rd_wen = 1'b1;
				r.exp_wen = 1'b1;
				case (op)
					exu_pkg::MEM_LB: r.exp_data = {{24{bmem[a][7]}}, bmem[a]};
					exu_pkg::MEM_LBU: r.exp_data = {24'd0, bmem[a]};
					exu_pkg::MEM_LH: r.exp_data = {{16{bmem[a+1][7]}}, bmem[a+1], bmem[a]};
					exu_pkg::MEM_LHU: r.exp_data = {16'd0, bmem[a+1], bmem[a]};
					default: r.exp_data = {bmem[a+3], bmem[a+2], bmem[a+1], bmem[a]};
				endcase
			end
		endcase
		rows.push_back(r);
	endtask

	// old csr value travels in src2 as decode would fetch it
	task automatic add_csr(exu_pkg::csr_op_e op, logic [11:0] idx, logic [31:0] a,
		logic [4:0] rdi);
		row_t r;
		r = blank_row(op.name());
		r.csr_op = op;
		r.csr_idx = idx;
		r.src1 = a;
		r.src2 = csr_model[csr_slot(idx)];
		r.alu_op = (op == exu_pkg::CSR_OP_RS) ? exu_pkg::ALU_OR : exu_pkg::ALU_ADD;
		r.rd = rdi;
		r.rd_wen = 1'b1;
		r.exp_wen = 1'b1;
		r.exp_data = r.src2;
		csr_model[csr_slot(idx)] = (op == exu_pkg::CSR_OP_RS) ? (a | r.src2) : a;
		r.n_csr = 1;
		r.csr_a[0] = idx;
		r.csr_e[0] = csr_model[csr_slot(idx)];
		rows.push_back(r);
	endtask

	task automatic add_ecall(logic [31:0] pci);
		row_t r;
		r = blank_row("ECALL");
		r.csr_op = exu_pkg::CSR_OP_ECALL;
		r.pc = pci;
		r.exp_redir = 1'b1;
		r.exp_rpc = csr_model[1];
		csr_model[2] = pci;
		csr_model[3] = `ECALL_CAUSE;
		r.n_csr = 2;
		r.csr_a[0] = `CSR_MEPC;
		r.csr_e[0] = pci;
		r.csr_a[1] = `CSR_MCAUSE;
		r.csr_e[1] = `ECALL_CAUSE;
		rows.push_back(r);
	endtask

	task automatic build_table();
		for (int k = 0; k <= int'(exu_pkg::ALU_PASS_B); k++)
			add_alu(exu_pkg::alu_op_e'(k), $random(seed), $random(seed), 5'(k + 1), 1'b1);
		add_alu(exu_pkg::ALU_ADD, $random(seed), $random(seed), 5'd3, 1'b0);
		add_jump(exu_pkg::JUMP_JAL, exu_pkg::ALU_ADD, 32'h40, 32'h40, 32'h20, 32'h0);
		add_jump(exu_pkg::JUMP_JALR, exu_pkg::ALU_ADD, 32'h60, 32'h203, 32'h10, 32'h0);
		add_jump(exu_pkg::JUMP_BRANCH, exu_pkg::ALU_EQ, 32'h70, 32'd5, 32'd5, 32'h80);
		add_jump(exu_pkg::JUMP_BRANCH, exu_pkg::ALU_NE, 32'h74, 32'd5, 32'd5, 32'h90);
		add_jump(exu_pkg::JUMP_BRANCH, exu_pkg::ALU_LT, 32'h78, 32'hffffffff, 32'd1, 32'ha0);
		add_jump(exu_pkg::JUMP_BRANCH, exu_pkg::ALU_GEU, 32'h7c, 32'hffffffff, 32'd1, 32'hb0);
		// memory ops mixed with alu ops for back-pressure
		add_mem(exu_pkg::MEM_SW, 32'h100, 32'd0, $random(seed), 5'd0);
		add_alu(exu_pkg::ALU_XOR, $random(seed), $random(seed), 5'd20, 1'b1);
		add_mem(exu_pkg::MEM_SW, 32'h100, 32'd4, $random(seed), 5'd0);
		for (int off = 0; off < 4; off++) begin
			add_mem(exu_pkg::MEM_LB, 32'h100, 32'(off), 32'h0, 5'd21);
			add_mem(exu_pkg::MEM_LBU, 32'h100, 32'(off), 32'h0, 5'd22);
		end
		add_mem(exu_pkg::MEM_LH, 32'h100, 32'd2, 32'h0, 5'd23);
		add_mem(exu_pkg::MEM_LHU, 32'h100, 32'd0, 32'h0, 5'd24);
		add_mem(exu_pkg::MEM_LW, 32'h100, 32'd0, 32'h0, 5'd25);
		add_mem(exu_pkg::MEM_SB, 32'h104, 32'd1, $random(seed), 5'd0);
		add_alu(exu_pkg::ALU_SUB, $random(seed), $random(seed), 5'd26, 1'b1);
		add_mem(exu_pkg::MEM_LB, 32'h104, 32'd1, 32'h0, 5'd27);
		add_mem(exu_pkg::MEM_LW, 32'h104, 32'd0, 32'h0, 5'd28);
		add_mem(exu_pkg::MEM_SH, 32'h104, 32'd2, $random(seed), 5'd0);
		add_mem(exu_pkg::MEM_LH, 32'h104, 32'd2, 32'h0, 5'd29);
		add_mem(exu_pkg::MEM_LHU, 32'h104, 32'd2, 32'h0, 5'd30);
		add_mem(exu_pkg::MEM_LW, 32'h104, 32'd0, 32'h0, 5'd31);
		add_mem(exu_pkg::MEM_LBU, 32'h100, 32'd5, 32'h0, 5'd2);
		add_csr(exu_pkg::CSR_OP_RW, `CSR_MSTATUS, $random(seed), 5'd10);
		add_csr(exu_pkg::CSR_OP_RS, `CSR_MSTATUS, $random(seed), 5'd11);
		add_csr(exu_pkg::CSR_OP_RW, `CSR_MEPC, $random(seed), 5'd12);
		add_csr(exu_pkg::CSR_OP_RS, `CSR_MCAUSE, 32'h5, 5'd13);
		add_ecall(32'h300);
		add_alu(exu_pkg::ALU_AND, $random(seed), $random(seed), 5'd14, 1'b1);
		add_alu(exu_pkg::ALU_OR, $random(seed), $random(seed), 5'd15, 1'b1);
	endtask

	task automatic drive_row(row_t r);
		in_valid = 1'b1;
		pc = r.pc;
		src1 = r.src1;
		src2 = r.src2;
		rd = r.rd;
		rd_wen = r.rd_wen;
		alu_op = r.alu_op;
		mem_op = r.mem_op;
		store_data = r.store_data;
		jump = r.jump;
		branch_target = r.branch_target;
		csr_op = r.csr_op;
		csr_idx = r.csr_idx;
	endtask

	task automatic check_row(int i);
		int row_err;
		row_err = 0;
		if (rf_wen !== rows[i].exp_wen) begin
			$display("Mismatch at %0t: row %0d rf_wen %b expected %b", $time, i, rf_wen,
				rows[i].exp_wen);
			row_err++;
		end else if (rf_wen && (rf_waddr !== rows[i].rd || rf_wdata !== rows[i].exp_data)) begin
			$display("Mismatch at %0t: row %0d rf write x%0d=%h expected x%0d=%h", $time, i,
				rf_waddr, rf_wdata, rows[i].rd, rows[i].exp_data);
			row_err++;
		end
		if (redirect_valid !== rows[i].exp_redir) begin
			$display("Mismatch at %0t: row %0d redirect_valid %b expected %b", $time, i,
				redirect_valid, rows[i].exp_redir);
			row_err++;
		end else if (redirect_valid && redirect_pc !== rows[i].exp_rpc) begin
			$display("Mismatch at %0t: row %0d redirect_pc %h expected %h", $time, i,
				redirect_pc, rows[i].exp_rpc);
			row_err++;
		end
		for (int c = 0; c < rows[i].n_csr; c++) begin
			rd_q_addr.push_back(rows[i].csr_a[c]);
			rd_q_exp.push_back(rows[i].csr_e[c]);
		end
		errors += row_err;
		if (row_err == 0)
			passed++;
		$display("row %0d %s: %s", i, rows[i].name, (row_err == 0) ? "pass" : "FAIL");
	endtask

	// retirement checker sampled at the falling edge
	initial begin
		csr_raddr = 12'h0;
		forever begin
			@(negedge clk);
			if (rst) begin
				if (done_valid || rf_wen || redirect_valid) begin
					$display("Mismatch at %0t: retire outputs active during reset", $time);
					errors++;
				end
			end else begin
				if (armed) begin
					if (csr_rdata !== rd_q_exp[0]) begin
						$display("Mismatch at %0t: csr %h reads %h expected %h", $time,
							rd_q_addr[0], csr_rdata, rd_q_exp[0]);
						errors++;
					end
					void'(rd_q_addr.pop_front());
					void'(rd_q_exp.pop_front());
					armed = 0;
				end
				if (done_valid) begin
					if (checked >= rows.size()) begin
						$display("unexpected retirement at %0t beyond the table", $time);
						errors++;
					end else begin
						check_row(checked);
						checked++;
					end
				end
				if (!allowin)
					stall_seen = 1;
				if (!armed && rd_q_addr.size() > 0) begin
					csr_raddr = rd_q_addr[0];
					armed = 1;
				end
			end
		end
	end

	initial begin
		int waited;
		rst = 1'b1;
		drive_row(blank_row("idle"));
		in_valid = 1'b0;
		for (int i = 0; i < 1024; i++)
			bmem[i] = 8'(i) ^ 8'(i >> 8);
		csr_model[0] = 32'h0;
		csr_model[1] = 32'h100;
		csr_model[2] = 32'h0;
		csr_model[3] = 32'h0;
		build_table();
		repeat (4) @(posedge clk);
		#1 rst = 1'b0;
		for (int i = 0; i < rows.size() && !timed_out; i++) begin
			drive_row(rows[i]);
			waited = 0;
			@(negedge clk);
			while (!allowin && waited < 100) begin
				@(negedge clk);
				waited++;
			end
			if (!allowin) begin
				$display("timed out waiting for allowin on row %0d", i);
				timed_out = 1;
			end
			@(posedge clk);
			#1;
		end
		in_valid = 1'b0;
		waited = 0;
		while (!timed_out && (checked < rows.size() || armed || rd_q_addr.size() > 0)
			&& waited < 4000) begin
			@(negedge clk);
			waited++;
		end
		if (waited >= 4000) begin
			$display("timed out waiting for all rows to retire");
			timed_out = 1;
		end
		if (!stall_seen) begin
			$display("allowin never dropped while a memory op was in flight");
			errors++;
		end
		$display("%0d rows checked, %0d passed, %0d errors", checked, passed, errors);
		if (errors == 0 && !timed_out && checked == rows.size())
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

/* verilog/alu.sv */
`timescale 1ns/1ps
`include "exu_consts.svh"

module alu (
	input  exu_pkg::alu_op_e  op,
	input  logic [`XLEN-1:0]  a,
	input  logic [`XLEN-1:0]  b,
	output logic [`XLEN-1:0]  result
);

	logic [4:0] shamt;
	logic       cmp;

	assign shamt = b[4:0];

	// compare flag for the set and branch opcodes
	always_comb begin
		case (op)
			exu_pkg::ALU_SLT,
			exu_pkg::ALU_LT:   cmp = $signed(a) < $signed(b);
			exu_pkg::ALU_SLTU,
			exu_pkg::ALU_LTU:  cmp = a < b;
			exu_pkg::ALU_EQ:   cmp = a == b;
			exu_pkg::ALU_NE:   cmp = a != b;
			exu_pkg::ALU_GE:   cmp = $signed(a) >= $signed(b);
			exu_pkg::ALU_GEU:  cmp = a >= b;
			default:           cmp = 1'b0;
		endcase
	end

	always_comb begin
		case (op)
			exu_pkg::ALU_ADD:    result = a + b;
			exu_pkg::ALU_SUB:    result = a - b;
			exu_pkg::ALU_SLL:    result = a << shamt;
			exu_pkg::ALU_XOR:    result = a ^ b;
			exu_pkg::ALU_SRL:    result = a >> shamt;
			exu_pkg::ALU_SRA:    result = $signed(a) >>> shamt;
			exu_pkg::ALU_OR:     result = a | b;
			exu_pkg::ALU_AND:    result = a & b;
			// lui immediate goes straight through
			exu_pkg::ALU_PASS_B: result = b;
			default:             result = {{(`XLEN-1){1'b0}}, cmp};
		endcase
	end

endmodule

/* verilog/csr_file.sv */
`timescale 1ns/1ps
`include "exu_consts.svh"

module csr_file (
	input  logic               clk,
	input  logic               rst,
	input  logic               wen,
	input  logic [`CSR_AW-1:0] waddr,
	input  logic [`XLEN-1:0]   wdata,
	input  logic               wen2,
	input  logic [`CSR_AW-1:0] waddr2,
	input  logic [`XLEN-1:0]   wdata2,
	input  logic [`CSR_AW-1:0] raddr,
	output logic [`XLEN-1:0]   rdata,
	output logic [`XLEN-1:0]   mtvec
);

	logic [`XLEN-1:0] mstatus, mepc, mcause;

	// port 2 comes last so it wins on a shared address
	always_ff @(posedge clk) begin
		if (rst) begin
			mstatus <= '0;
			mtvec   <= `XLEN'('h100);
			mepc    <= '0;
			mcause  <= '0;
		end else begin
			if (wen && waddr == `CSR_MSTATUS)
				mstatus <= wdata;
			if (wen && waddr == `CSR_MTVEC)
				mtvec <= wdata;
			if (wen && waddr == `CSR_MEPC)
				mepc <= wdata;
			if (wen && waddr == `CSR_MCAUSE)
				mcause <= wdata;
			if (wen2 && waddr2 == `CSR_MSTATUS)
				mstatus <= wdata2;
			if (wen2 && waddr2 == `CSR_MTVEC)
				mtvec <= wdata2;
			if (wen2 && waddr2 == `CSR_MEPC)
				mepc <= wdata2;
			if (wen2 && waddr2 == `CSR_MCAUSE)
				mcause <= wdata2;
		end
	end

	always_comb begin
		case (raddr)
			`CSR_MSTATUS: rdata = mstatus;
			`CSR_MTVEC:   rdata = mtvec;
			`CSR_MEPC:    rdata = mepc;
			`CSR_MCAUSE:  rdata = mcause;
			default:      rdata = '0;
		endcase
	end

endmodule

/* verilog/data_sram.sv */
`timescale 1ns/1ps
`include "exu_consts.svh"

module data_sram #(
	parameter int DEPTH = `DMEM_WORDS
) (
	input  logic             clk,
	input  logic             rst,
	input  logic [`XLEN-1:0] awaddr,
	input  logic             awvalid,
	output logic             awready,
	input  logic [`XLEN-1:0] wdata,
	input  logic [3:0]       wstrb,
	input  logic             wvalid,
	output logic             wready,
	output logic [1:0]       bresp,
	output logic             bvalid,
	input  logic             bready,
	input  logic [`XLEN-1:0] araddr,
	input  logic             arvalid,
	output logic             arready,
	output logic [`XLEN-1:0] rdata,
	output logic [1:0]       rresp,
	output logic             rvalid,
	input  logic             rready
);

	localparam int IDX_W = $clog2(DEPTH);

	logic [`XLEN-1:0] mem [DEPTH];
	logic [`XLEN-1:0] aw_addr_q, ar_word, aw_word;
	logic             aw_got;

	// word index wraps at DEPTH
	assign ar_word = (araddr >> 2) % DEPTH;
	assign aw_word = (aw_addr_q >> 2) % DEPTH;

	// one wait cycle before each address ready
	always_ff @(posedge clk) begin
		if (rst) begin
			arready <= 1'b0;
			rvalid  <= 1'b0;
			awready <= 1'b0;
			aw_got  <= 1'b0;
			bvalid  <= 1'b0;
		end else begin
			arready <= arvalid && !arready && !rvalid;
			if (rvalid && rready)
				rvalid <= 1'b0;
			else if (arvalid && arready)
				rvalid <= 1'b1;
			awready <= awvalid && !awready && !aw_got && !bvalid;
			if (awvalid && awready)
				aw_got <= 1'b1;
			else if (wvalid && wready)
				aw_got <= 1'b0;
			if (bvalid && bready)
				bvalid <= 1'b0;
			else if (wvalid && wready)
				bvalid <= 1'b1;
		end
	end

	// data phase opens once the address is taken
	assign wready = aw_got;
	assign bresp  = 2'b00;
	assign rresp  = 2'b00;

	always_ff @(posedge clk) begin
		if (arvalid && arready)
			rdata <= mem[ar_word[IDX_W-1:0]];
		if (awvalid && awready)
			aw_addr_q <= awaddr;
		if (wvalid && wready) begin
			for (int b = 0; b < 4; b++) begin
				if (wstrb[b])
					mem[aw_word[IDX_W-1:0]][8*b +: 8] <= wdata[8*b +: 8];
			end
		end
	end

endmodule

/* verilog/exu.sv */
`timescale 1ns/1ps
`include "exu_consts.svh"

module exu (
	input  logic               clk,
	input  logic               rst,
	// decode side
	input  logic               in_valid,
	input  logic [`XLEN-1:0]   pc,
	input  logic [`XLEN-1:0]   src1,
	input  logic [`XLEN-1:0]   src2,
	input  logic [`REG_AW-1:0] rd,
	input  logic               rd_wen,
	input  exu_pkg::alu_op_e   alu_op,
	input  exu_pkg::mem_op_e   mem_op,
	input  logic [`XLEN-1:0]   store_data,
	input  exu_pkg::jump_e     jump,
	input  logic [`XLEN-1:0]   branch_target,
	input  exu_pkg::csr_op_e   csr_op,
	input  logic [`CSR_AW-1:0] csr_idx,
	output logic               allowin,
	// retire side
	output logic               done_valid,
	output logic               redirect_valid,
	output logic [`XLEN-1:0]   redirect_pc,
	output logic               rf_wen,
	output logic [`REG_AW-1:0] rf_waddr,
	output logic [`XLEN-1:0]   rf_wdata,
	// csr file
	output logic               csr_wen,
	output logic [`CSR_AW-1:0] csr_waddr,
	output logic [`XLEN-1:0]   csr_wdata,
	output logic               csr_wen2,
	output logic [`CSR_AW-1:0] csr_waddr2,
	output logic [`XLEN-1:0]   csr_wdata2,
	input  logic [`XLEN-1:0]   mtvec,
	// data memory bus
	output logic [`XLEN-1:0]   awaddr,
	output logic               awvalid,
	input  logic               awready,
	output logic [`XLEN-1:0]   wdata,
	output logic [3:0]         wstrb,
	output logic               wvalid,
	input  logic               wready,
	input  logic [1:0]         bresp,
	input  logic               bvalid,
	output logic               bready,
	output logic [`XLEN-1:0]   araddr,
	output logic               arvalid,
	input  logic               arready,
	input  logic [`XLEN-1:0]   rdata,
	input  logic [1:0]         rresp,
	input  logic               rvalid,
	output logic               rready
);

	logic               valid_q, rd_wen_q;
	logic [`XLEN-1:0]   pc_q, src1_q, src2_q, store_data_q, branch_target_q;
	logic [`REG_AW-1:0] rd_q;
	logic [`CSR_AW-1:0] csr_idx_q;
	exu_pkg::alu_op_e   alu_op_q;
	exu_pkg::mem_op_e   mem_op_q;
	exu_pkg::jump_e     jump_q;
	exu_pkg::csr_op_e   csr_op_q;
	logic [`XLEN-1:0]   alu_result, load_data;
	logic               is_mem, req_valid, mem_done, ready_go, branch_taken, is_ecall;

	always_ff @(posedge clk) begin
		if (rst)
			valid_q <= 1'b0;
		else if (allowin)
			valid_q <= in_valid;
	end

	always_ff @(posedge clk) begin
		if (allowin && in_valid) begin
			pc_q            <= pc;
			src1_q          <= src1;
			src2_q          <= src2;
			rd_q            <= rd;
			rd_wen_q        <= rd_wen;
			alu_op_q        <= alu_op;
			mem_op_q        <= mem_op;
			store_data_q    <= store_data;
			jump_q          <= jump;
			branch_target_q <= branch_target;
			csr_op_q        <= csr_op;
			csr_idx_q       <= csr_idx;
		end
	end

	// memory ops hold the stage until the bus finishes
	assign is_mem     = mem_op_q != exu_pkg::MEM_NONE;
	assign req_valid  = valid_q && is_mem;
	assign ready_go   = !is_mem || mem_done;
	assign allowin    = !valid_q || ready_go;
	assign done_valid = valid_q && ready_go;

	alu i_alu (
		.op     (alu_op_q),
		.a      (src1_q),
		.b      (src2_q),
		.result (alu_result)
	);

	lsu i_lsu (
		.clk, .rst, .req_valid,
		.mem_op     (mem_op_q),
		.addr       (alu_result),
		.store_data (store_data_q),
		.mem_done, .load_data,
		.awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
		.bresp, .bvalid, .bready,
		.araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready
	);

	assign branch_taken = (jump_q == exu_pkg::JUMP_BRANCH) && alu_result[0];
	assign is_ecall     = csr_op_q == exu_pkg::CSR_OP_ECALL;

	always_comb begin
		case (jump_q)
			exu_pkg::JUMP_JAL:    redirect_pc = alu_result;
			exu_pkg::JUMP_JALR:   redirect_pc = {alu_result[`XLEN-1:1], 1'b0};
			exu_pkg::JUMP_BRANCH: redirect_pc = branch_target_q;
			default:              redirect_pc = mtvec;
		endcase
	end

	assign redirect_valid = done_valid && (jump_q inside {exu_pkg::JUMP_JAL,
		exu_pkg::JUMP_JALR} || branch_taken || is_ecall);

	// writeback select
	always_comb begin
		if (jump_q inside {exu_pkg::JUMP_JAL, exu_pkg::JUMP_JALR})
			rf_wdata = pc_q + `XLEN'd4;
		else if (is_mem)
			rf_wdata = load_data;
		else if (csr_op_q inside {exu_pkg::CSR_OP_RW, exu_pkg::CSR_OP_RS})
			rf_wdata = src2_q;
		else
			rf_wdata = alu_result;
	end

	assign rf_wen   = done_valid && rd_wen_q;
	assign rf_waddr = rd_q;

	// csrrs takes src1 | old value from the alu
	assign csr_wen   = done_valid && csr_op_q != exu_pkg::CSR_OP_NONE;
	assign csr_waddr = is_ecall ? `CSR_MEPC : csr_idx_q;
	assign csr_wdata = (csr_op_q == exu_pkg::CSR_OP_RW) ? src1_q :
		(csr_op_q == exu_pkg::CSR_OP_RS) ? alu_result : pc_q;

	assign csr_wen2   = done_valid && is_ecall;
	assign csr_waddr2 = `CSR_MCAUSE;
	assign csr_wdata2 = `ECALL_CAUSE;

endmodule

/* verilog/exu_consts.svh */
`ifndef EXU_CONSTS_SVH
`define EXU_CONSTS_SVH

// datapath widths
`define XLEN 32
`define REG_AW 5
`define CSR_AW 12

// machine mode csr addresses
`define CSR_MSTATUS 12'h300
`define CSR_MTVEC 12'h305
`define CSR_MEPC 12'h341
`define CSR_MCAUSE 12'h342

// environment call from m-mode
`define ECALL_CAUSE 32'd11

`define DMEM_WORDS 256

`endif

/* verilog/exu_pkg.sv */
package exu_pkg;

	typedef enum logic [4:0] {
		ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
		ALU_SRL, ALU_SRA, ALU_OR, ALU_AND,
		// compares return 0 or 1
		ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU,
		ALU_PASS_B
	} alu_op_e;

	typedef enum logic [3:0] {
		MEM_NONE, MEM_LB, MEM_LBU, MEM_LH, MEM_LHU, MEM_LW,
		MEM_SB, MEM_SH, MEM_SW
	} mem_op_e;

	typedef enum logic [1:0] {JUMP_NONE, JUMP_JAL, JUMP_JALR, JUMP_BRANCH} jump_e;

	typedef enum logic [1:0] {CSR_OP_NONE, CSR_OP_RW, CSR_OP_RS, CSR_OP_ECALL} csr_op_e;

	// read channel sequence
	typedef enum logic [2:0] {
		IDLE_R, WAIT_ARREADY, SHAKED_AR, WAIT_RVALID, SHAKED_R
	} rd_state_e;

	// write channel sequence with data only after address
	typedef enum logic [2:0] {
		IDLE_W, WAIT_AWREADY, SHAKED_AW, WAIT_WREADY, SHAKED_W,
		WAIT_BVALID, SHAKED_B
	} wr_state_e;

endpackage

/* verilog/exu_top.sv */
`timescale 1ns/1ps
`include "exu_consts.svh"

module exu_top (
	input  logic               clk,
	input  logic               rst,
	input  logic               in_valid,
	input  logic [`XLEN-1:0]   pc,
	input  logic [`XLEN-1:0]   src1,
	input  logic [`XLEN-1:0]   src2,
	input  logic [`REG_AW-1:0] rd,
	input  logic               rd_wen,
	input  exu_pkg::alu_op_e   alu_op,
	input  exu_pkg::mem_op_e   mem_op,
	input  logic [`XLEN-1:0]   store_data,
	input  exu_pkg::jump_e     jump,
	input  logic [`XLEN-1:0]   branch_target,
	input  exu_pkg::csr_op_e   csr_op,
	input  logic [`CSR_AW-1:0] csr_idx,
	output logic               allowin,
	output logic               done_valid,
	output logic               redirect_valid,
	output logic [`XLEN-1:0]   redirect_pc,
	output logic               rf_wen,
	output logic [`REG_AW-1:0] rf_waddr,
	output logic [`XLEN-1:0]   rf_wdata,
	input  logic [`CSR_AW-1:0] csr_raddr,
	output logic [`XLEN-1:0]   csr_rdata
);

	logic               csr_wen, csr_wen2;
	logic [`CSR_AW-1:0] csr_waddr, csr_waddr2;
	logic [`XLEN-1:0]   csr_wdata, csr_wdata2, mtvec;
	// data memory bus
	logic [`XLEN-1:0]   awaddr, wdata, araddr, rdata;
	logic [3:0]         wstrb;
	logic [1:0]         bresp, rresp;
	logic               awvalid, awready, wvalid, wready, bvalid, bready;
	logic               arvalid, arready, rvalid, rready;

	exu i_exu (.*);

	csr_file i_csr_file (
		.clk, .rst,
		.wen    (csr_wen),
		.waddr  (csr_waddr),
		.wdata  (csr_wdata),
		.wen2   (csr_wen2),
		.waddr2 (csr_waddr2),
		.wdata2 (csr_wdata2),
		.raddr  (csr_raddr),
		.rdata  (csr_rdata),
		.mtvec
	);

	data_sram #(.DEPTH(`DMEM_WORDS)) i_data_sram (.*);

endmodule

/* verilog/lsu.sv */
`timescale 1ns/1ps
`include "exu_consts.svh"

module lsu (
	input  logic               clk,
	input  logic               rst,
	input  logic               req_valid,
	input  exu_pkg::mem_op_e   mem_op,
	input  logic [`XLEN-1:0]   addr,
	input  logic [`XLEN-1:0]   store_data,
	output logic               mem_done,
	output logic [`XLEN-1:0]   load_data,
	output logic [`XLEN-1:0]   awaddr,
	output logic               awvalid,
	input  logic               awready,
	output logic [`XLEN-1:0]   wdata,
	output logic [3:0]         wstrb,
	output logic               wvalid,
	input  logic               wready,
	input  logic [1:0]         bresp,
	input  logic               bvalid,
	output logic               bready,
	output logic [`XLEN-1:0]   araddr,
	output logic               arvalid,
	input  logic               arready,
	input  logic [`XLEN-1:0]   rdata,
	input  logic [1:0]         rresp,
	input  logic               rvalid,
	output logic               rready
);

	exu_pkg::rd_state_e state_r, next_r;
	exu_pkg::wr_state_e state_w, next_w;
	logic               read_start, write_start;
	logic               arvalid_q, awvalid_q;
	logic [4:0]         byte_shift;
	logic [3:0]         strb;
	logic [`XLEN-1:0]   rdata_q, rshift;

	assign read_start = req_valid && mem_op inside {exu_pkg::MEM_LB, exu_pkg::MEM_LBU,
		exu_pkg::MEM_LH, exu_pkg::MEM_LHU, exu_pkg::MEM_LW};
	assign write_start = req_valid && mem_op inside {exu_pkg::MEM_SB, exu_pkg::MEM_SH,
		exu_pkg::MEM_SW};
	assign byte_shift = {addr[1:0], 3'b000};

	// read channel
	always_comb begin
		next_r = state_r;
		case (state_r)
			exu_pkg::IDLE_R:
				if (read_start)
					next_r = arready ? exu_pkg::SHAKED_AR : exu_pkg::WAIT_ARREADY;
			exu_pkg::WAIT_ARREADY:
				if (arready)
					next_r = exu_pkg::SHAKED_AR;
			exu_pkg::SHAKED_AR:
				next_r = rvalid ? exu_pkg::SHAKED_R : exu_pkg::WAIT_RVALID;
			exu_pkg::WAIT_RVALID:
				if (rvalid)
					next_r = exu_pkg::SHAKED_R;
			// stage retires the load on this edge
			default:
				next_r = exu_pkg::IDLE_R;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state_r   <= exu_pkg::IDLE_R;
			arvalid_q <= 1'b0;
			rready    <= 1'b0;
		end else begin
			state_r   <= next_r;
			arvalid_q <= next_r == exu_pkg::WAIT_ARREADY;
			rready    <= next_r inside {exu_pkg::SHAKED_AR, exu_pkg::WAIT_RVALID};
		end
	end

	assign arvalid = (state_r == exu_pkg::IDLE_R) ? read_start : arvalid_q;
	assign araddr  = addr;

	always_ff @(posedge clk) begin
		if (rvalid && rready)
			rdata_q <= rdata;
	end

	// write channel
	always_comb begin
		next_w = state_w;
		case (state_w)
			exu_pkg::IDLE_W:
				if (write_start)
					next_w = awready ? exu_pkg::SHAKED_AW : exu_pkg::WAIT_AWREADY;
			exu_pkg::WAIT_AWREADY:
				if (awready)
					next_w = exu_pkg::SHAKED_AW;
			exu_pkg::SHAKED_AW:
				next_w = wready ? exu_pkg::SHAKED_W : exu_pkg::WAIT_WREADY;
			exu_pkg::WAIT_WREADY:
				if (wready)
					next_w = exu_pkg::SHAKED_W;
			exu_pkg::SHAKED_W:
				next_w = bvalid ? exu_pkg::SHAKED_B : exu_pkg::WAIT_BVALID;
			exu_pkg::WAIT_BVALID:
				if (bvalid)
					next_w = exu_pkg::SHAKED_B;
			default:
				next_w = exu_pkg::IDLE_W;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state_w   <= exu_pkg::IDLE_W;
			awvalid_q <= 1'b0;
			wvalid    <= 1'b0;
			bready    <= 1'b0;
		end else begin
			state_w   <= next_w;
			awvalid_q <= next_w == exu_pkg::WAIT_AWREADY;
			wvalid    <= next_w inside {exu_pkg::SHAKED_AW, exu_pkg::WAIT_WREADY};
			bready    <= next_w inside {exu_pkg::SHAKED_W, exu_pkg::WAIT_BVALID};
		end
	end

	assign awvalid = (state_w == exu_pkg::IDLE_W) ? write_start : awvalid_q;
	assign awaddr  = addr;

	// byte lanes from size and low address bits
	always_comb begin
		case (mem_op)
			exu_pkg::MEM_SB: strb = 4'b0001 << addr[1:0];
			exu_pkg::MEM_SH: strb = 4'b0011 << {addr[1], 1'b0};
			default:         strb = 4'b1111;
		endcase
	end

	// data phase payload latched at the aw handshake
	always_ff @(posedge clk) begin
		if (awvalid && awready) begin
			wdata <= store_data << byte_shift;
			wstrb <= strb;
		end
	end

	// load alignment and extension
	assign rshift = rdata_q >> byte_shift;

	always_comb begin
		case (mem_op)
			exu_pkg::MEM_LB:  load_data = {{(`XLEN-8){rshift[7]}}, rshift[7:0]};
			exu_pkg::MEM_LBU: load_data = {{(`XLEN-8){1'b0}}, rshift[7:0]};
			exu_pkg::MEM_LH:  load_data = {{(`XLEN-16){rshift[15]}}, rshift[15:0]};
			exu_pkg::MEM_LHU: load_data = {{(`XLEN-16){1'b0}}, rshift[15:0]};
			default:          load_data = rdata_q;
		endcase
	end

	assign mem_done = (state_r == exu_pkg::SHAKED_R) || (state_w == exu_pkg::SHAKED_B);

	ar_hold: assert property (@(posedge clk) disable iff (rst)
		arvalid && !arready |=> arvalid);
	aw_hold: assert property (@(posedge clk) disable iff (rst)
		awvalid && !awready |=> awvalid);
	done_busy: assert property (@(posedge clk) disable iff (rst)
		mem_done |-> req_valid);
	// error responses still complete and are only flagged
	rresp_ok: assert property (@(posedge clk) disable iff (rst)
		rvalid && rready |-> rresp == 2'b00)
		else $error("lsu: read error response");
	bresp_ok: assert property (@(posedge clk) disable iff (rst)
		bvalid && bready |-> bresp == 2'b00)
		else $error("lsu: write error response");

endmodule
